// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int xlen = 32;
	// one address selects a pair of words
	localparam int pc_w = 13;
	localparam int win_depth = 3;

	// field types, also used by the instruction format
	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] op_bits_t;
	typedef logic [15:0] imm_t;

	typedef struct packed {
		logic valid;
		op_bits_t opcode;
		reg_idx_t ds;
		logic ds_used;
		reg_idx_t dt;
		logic dt_used;
		reg_idx_t dd;
		logic dd_used;
		imm_t imm;
		logic long_lat;
	} uop_t;

	typedef struct packed {
		logic valid;
		op_bits_t opcode;
		reg_idx_t dd;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		imm_t imm;
	} issue_t;

	typedef struct packed {
		logic valid;
		reg_idx_t dd;
		logic [xlen-1:0] data;
	} wb_t;

	// word[1] is the older instruction
	typedef struct packed {
		logic valid;
		logic [1:0][xlen-1:0] word;
	} fetch_pair_t;

	typedef enum logic {
		st_begin,
		st_normal
	} fsm_state_t;

endpackage

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int instr_w = 32;
	localparam int reg_idx_w = $bits(core_pkg::reg_idx_t);

	typedef enum logic [$bits(core_pkg::op_bits_t)-1:0] {
		nop    = 6'd0,
		add    = 6'd1,
		sub    = 6'd2,
		and_op = 6'd3,
		or_op  = 6'd4,
		xor_op = 6'd5,
		addi   = 6'd6,
		shli   = 6'd7,
		mul    = 6'd8
	} opcode_t;

	// dt shares its bits with the top of imm
	typedef struct packed {
		logic [reg_idx_w-1:0] dt;
		logic [$bits(core_pkg::imm_t)-reg_idx_w-1:0] rest;
	} r_low_t;

	typedef union packed {
		r_low_t r;
		core_pkg::imm_t imm;
	} low_t;

	typedef struct packed {
		opcode_t opcode;
		logic [reg_idx_w-1:0] dd;
		logic [reg_idx_w-1:0] ds;
		low_t low;
	} instr_t;

	localparam int alu_lat = 1;
	localparam int mul_lat = 3;
	localparam int slot_w = 3;

	function automatic core_pkg::uop_t decode(input logic [instr_w-1:0] word);
		instr_t ins;
		core_pkg::uop_t u;
		ins = word;
		u = '0;
		u.valid = 1'b1;
		u.opcode = ins.opcode;
		u.ds = ins.ds;
		u.dt = ins.low.r.dt;
		u.dd = ins.dd;
		u.imm = ins.low.imm;
		case (ins.opcode)
			add, sub, and_op, or_op, xor_op, mul: begin
				u.ds_used = 1'b1;
				u.dt_used = 1'b1;
				u.dd_used = 1'b1;
			end
			addi, shli: begin
				u.ds_used = 1'b1;
				u.dd_used = 1'b1;
			end
			default: ;
		endcase
		u.long_lat = (ins.opcode == mul);
		// writes to r0 are dropped here
		if (ins.dd == '0)
			u.dd_used = 1'b0;
		return u;
	endfunction

endpackage

`default_nettype wire

// File: hdl/fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
	input  logic clk,
	input  logic rstn,
	input  logic i_stall,
	input  logic [2*isa_pkg::instr_w-1:0] i_rdata,
	output logic [core_pkg::pc_w-1:0] o_addr,
	output core_pkg::fetch_pair_t o_pair
);
	import core_pkg::*;
	import isa_pkg::*;

	fsm_state_t state;
	logic [pc_w-1:0] pc;
	logic req_vld;
	logic rd_vld;
	logic stall_q;
	logic skid_vld;
	logic [2*instr_w-1:0] skid_words;
	logic pair_vld;
	logic [2*instr_w-1:0] pair_words;

	// the begin cycle issues no request
	assign req_vld = (state == st_normal);
	assign o_addr = pc;

	assign o_pair.valid = pair_vld;
	assign o_pair.word = pair_words;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_begin;
			pc <= '0;
			rd_vld <= 1'b0;
			stall_q <= 1'b0;
			skid_vld <= 1'b0;
			pair_vld <= 1'b0;
		end else begin
			case (state)
				st_begin: state <= st_normal;
				st_normal: begin
					if (!i_stall)
						pc <= pc + 1'b1;
				end
				default: state <= st_begin;
			endcase
			// read data lags its address by one cycle
			rd_vld <= req_vld;
			stall_q <= i_stall;
			// first stalled cycle, park the pair in flight
			if (i_stall && !stall_q)
				skid_vld <= rd_vld;
			if (!i_stall)
				pair_vld <= stall_q ? skid_vld : rd_vld;
		end
		if (i_stall && !stall_q)
			skid_words <= i_rdata;
		// replay the parked pair once the stall drops
		if (!i_stall)
			pair_words <= stall_q ? skid_words : i_rdata;
	end

endmodule

`default_nettype wire

// File: hdl/issue_window.sv
`timescale 1ns/1ps
`default_nettype none

module issue_window (
	input  logic clk,
	input  logic rstn,
	input  core_pkg::fetch_pair_t i_pair,
	input  core_pkg::wb_t i_wb,
	input  logic [isa_pkg::slot_w-1:0] i_slot_busy,
	input  logic [core_pkg::xlen-1:0] i_rd_a,
	input  logic [core_pkg::xlen-1:0] i_rd_b,
	output logic [isa_pkg::reg_idx_w-1:0] o_rs_a,
	output logic [isa_pkg::reg_idx_w-1:0] o_rs_b,
	output logic o_stall,
	output core_pkg::issue_t o_issue
);
	import core_pkg::*;
	import isa_pkg::*;

	localparam int nreg = 2**reg_idx_w;

	uop_t win [win_depth];
	uop_t cand [win_depth+2];
	uop_t nxt [win_depth];
	uop_t sel;
	logic [win_depth-1:0] win_vld;
	logic [nreg-1:0] sb;
	logic [nreg-1:0] sb_set;
	logic [nreg-1:0] sb_clr;
	logic [nreg-1:0] src_m [win_depth];
	logic [nreg-1:0] dst_m [win_depth];
	logic [win_depth-1:0] ready;
	logic [win_depth-1:0] issue_sel;

	// per-entry register masks, r0 never blocks
	always_comb begin
		for (int i = 0; i < win_depth; i++) begin
			win_vld[i] = win[i].valid;
			src_m[i] = '0;
			dst_m[i] = '0;
			if (win[i].valid && win[i].ds_used)
				src_m[i][win[i].ds] = 1'b1;
			if (win[i].valid && win[i].dt_used)
				src_m[i][win[i].dt] = 1'b1;
			if (win[i].valid && win[i].dd_used)
				dst_m[i][win[i].dd] = 1'b1;
			src_m[i][0] = 1'b0;
			dst_m[i][0] = 1'b0;
		end
	end

	// raw vs in-flight and older, war and waw vs older
	always_comb begin
		logic [nreg-1:0] older_src;
		logic [nreg-1:0] older_dst;
		older_src = '0;
		older_dst = '0;
		for (int i = 0; i < win_depth; i++) begin
			ready[i] = win[i].valid
				&& ((src_m[i] | dst_m[i]) & sb) == '0
				&& (src_m[i] & older_dst) == '0
				&& (dst_m[i] & (older_src | older_dst)) == '0
				&& !i_slot_busy[win[i].long_lat ? mul_lat - 1 : alu_lat - 1];
			older_src |= src_m[i];
			older_dst |= dst_m[i];
		end
		// oldest ready entry wins
		issue_sel = ready & (~ready + 1'b1);
	end

	always_comb begin
		sel = '0;
		for (int i = 0; i < win_depth; i++)
			if (issue_sel[i])
				sel = win[i];
	end

	assign o_rs_a = sel.ds_used ? sel.ds : '0;
	assign o_rs_b = sel.dt_used ? sel.dt : '0;

	assign o_issue.valid = |issue_sel;
	assign o_issue.opcode = sel.opcode;
	assign o_issue.dd = sel.dd_used ? sel.dd : '0;
	assign o_issue.a = i_rd_a;
	assign o_issue.b = i_rd_b;
	assign o_issue.imm = sel.imm;

	// survivors first, then the older word, then the younger
	always_comb begin
		int n;
		n = 0;
		for (int i = 0; i < win_depth; i++) begin
			cand[i] = win[i];
			cand[i].valid = win[i].valid && !issue_sel[i];
			n += int'(cand[i].valid);
		end
		o_stall = (n > win_depth - 2);
		cand[win_depth] = decode(i_pair.word[1]);
		cand[win_depth].valid = i_pair.valid && !o_stall;
		cand[win_depth+1] = decode(i_pair.word[0]);
		cand[win_depth+1].valid = i_pair.valid && !o_stall;
	end

	always_comb begin
		int k;
		k = 0;
		for (int i = 0; i < win_depth; i++)
			nxt[i] = '0;
		for (int c = 0; c < win_depth + 2; c++) begin
			if (cand[c].valid && k < win_depth) begin
				nxt[k] = cand[c];
				k++;
			end
		end
	end

	always_comb begin
		sb_set = '0;
		sb_clr = '0;
		if (o_issue.valid && sel.dd_used)
			sb_set[sel.dd] = 1'b1;
		if (i_wb.valid)
			sb_clr[i_wb.dd] = 1'b1;
		sb_set[0] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			sb <= '0;
			for (int i = 0; i < win_depth; i++)
				win[i].valid <= 1'b0;
		end else begin
			sb <= (sb & ~sb_clr) | sb_set;
			for (int i = 0; i < win_depth; i++)
				win[i] <= nxt[i];
		end
	end

	// entry count moves by the accepted pair less the single issue
	a_one_issue: assert property (@(posedge clk) disable iff (!rstn)
		$countones(win_vld) == $countones($past(win_vld)) - int'($past(o_issue.valid))
			+ ($past(i_pair.valid && !o_stall) ? 2 : 0));

	// a second issue to a busy destination would retire with its bit already clear
	a_no_reissue: assert property (@(posedge clk) disable iff (!rstn)
		i_wb.valid |-> sb[i_wb.dd]);

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic clk,
	input  core_pkg::reg_idx_t i_rs_a,
	input  core_pkg::reg_idx_t i_rs_b,
	output logic [core_pkg::xlen-1:0] o_rd_a,
	output logic [core_pkg::xlen-1:0] o_rd_b,
	input  core_pkg::wb_t i_wb
);
	import core_pkg::*;

	localparam int nreg = 2**$bits(reg_idx_t);

	logic [xlen-1:0] regs [nreg];

	// r0 is hardwired to zero
	assign o_rd_a = (i_rs_a == '0) ? '0 : regs[i_rs_a];
	assign o_rd_b = (i_rs_b == '0) ? '0 : regs[i_rs_b];

	always_ff @(posedge clk) begin
		if (i_wb.valid && i_wb.dd != '0)
			regs[i_wb.dd] <= i_wb.data;
	end

	// exec_unit filters out writes to r0
	a_no_r0_write: assert property (@(posedge clk) i_wb.valid |-> i_wb.dd != '0);

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic clk,
	input  logic rstn,
	input  core_pkg::issue_t i_issue,
	output logic [isa_pkg::slot_w-1:0] o_slot_busy,
	output core_pkg::wb_t o_wb
);
	import core_pkg::*;
	import isa_pkg::*;

	opcode_t op;
	logic is_mul;
	logic alu_go;
	logic [xlen-1:0] imm_sx;
	logic [xlen-1:0] alu_res;
	wb_t mul_s1;
	wb_t mul_s2;
	logic [slot_w-1:0] slot_q;
	logic [slot_w-1:0] slot_cur;
	reg_idx_t wb_dd;

	assign op = opcode_t'(i_issue.opcode);
	assign is_mul = (op == mul);
	assign alu_go = i_issue.valid && !is_mul;
	assign imm_sx = xlen'($signed(i_issue.imm));

	always_comb begin
		case (op)
			add:     alu_res = i_issue.a + i_issue.b;
			sub:     alu_res = i_issue.a - i_issue.b;
			and_op:  alu_res = i_issue.a & i_issue.b;
			or_op:   alu_res = i_issue.a | i_issue.b;
			xor_op:  alu_res = i_issue.a ^ i_issue.b;
			addi:    alu_res = i_issue.a + imm_sx;
			shli:    alu_res = i_issue.a << i_issue.imm[$clog2(xlen)-1:0];
			default: alu_res = '0;
		endcase
	end

	// bit k set means the writeback register loads k cycles from now
	always_comb begin
		slot_cur = slot_q;
		if (i_issue.valid)
			slot_cur[is_mul ? mul_lat - 1 : alu_lat - 1] = 1'b1;
	end

	assign o_slot_busy = slot_q;

	// a due multiply owns the write port
	assign wb_dd = mul_s2.valid ? mul_s2.dd : i_issue.dd;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			slot_q <= '0;
			mul_s1.valid <= 1'b0;
			mul_s2.valid <= 1'b0;
			o_wb.valid <= 1'b0;
		end else begin
			slot_q <= slot_cur >> 1;
			mul_s1.valid <= i_issue.valid && is_mul;
			mul_s2.valid <= mul_s1.valid;
			o_wb.valid <= slot_cur[0] && wb_dd != '0;
		end
		// low half of the product only
		mul_s1.dd <= i_issue.dd;
		mul_s1.data <= i_issue.a * i_issue.b;
		mul_s2.dd <= mul_s1.dd;
		mul_s2.data <= mul_s1.data;
		o_wb.dd <= wb_dd;
		o_wb.data <= mul_s2.valid ? mul_s2.data : alu_res;
	end

	// window must honour the slot mask two cycles after a mul
	a_no_collide: assert property (@(posedge clk) disable iff (!rstn)
		!(mul_s2.valid && alu_go));

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  logic clk,
	input  logic rstn,
	output logic [core_pkg::pc_w-1:0] o_i_addr,
	input  logic [2*isa_pkg::instr_w-1:0] i_i_rdata,
	output core_pkg::wb_t o_wb
);
	import core_pkg::*;
	import isa_pkg::*;

	fetch_pair_t pair;
	logic stall;
	issue_t issue;
	logic [slot_w-1:0] slot_busy;
	logic [reg_idx_w-1:0] rs_a;
	logic [reg_idx_w-1:0] rs_b;
	logic [xlen-1:0] rd_a;
	logic [xlen-1:0] rd_b;

	fetch_control u_fetch (
		.clk     (clk),
		.rstn    (rstn),
		.i_stall (stall),
		.i_rdata (i_i_rdata),
		.o_addr  (o_i_addr),
		.o_pair  (pair)
	);

	issue_window u_window (
		.clk         (clk),
		.rstn        (rstn),
		.i_pair      (pair),
		.i_wb        (o_wb),
		.i_slot_busy (slot_busy),
		.i_rd_a      (rd_a),
		.i_rd_b      (rd_b),
		.o_rs_a      (rs_a),
		.o_rs_b      (rs_b),
		.o_stall     (stall),
		.o_issue     (issue)
	);

	reg_file u_regs (
		.clk    (clk),
		.i_rs_a (rs_a),
		.i_rs_b (rs_b),
		.o_rd_a (rd_a),
		.o_rd_b (rd_b),
		.i_wb   (o_wb)
	);

	exec_unit u_exec (
		.clk         (clk),
		.rstn        (rstn),
		.i_issue     (issue),
		.o_slot_busy (slot_busy),
		.o_wb        (o_wb)
	);

endmodule

`default_nettype wire

// File: bench/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;
	import core_pkg::*;
	import isa_pkg::*;

	localparam int nreg = 2**reg_idx_w;
	localparam int half_period = 20;
	localparam int reset_cycles = 5;
	localparam int random_count = 200;
	localparam logic [31:0] seed = 32'hbd4b_3a0e;
	// every instruction still in the pipe may be a dependent mul
	localparam int drain_cycles = 2 * (mul_lat + 1) * (win_depth + 6);

	logic clk;
	logic rstn;
	logic [pc_w-1:0] imem_addr;
	logic [2*instr_w-1:0] imem_rdata;
	wb_t wb;

	logic [instr_w-1:0] prog [$];
	wb_t exp_q [nreg][$];
	int exp_total;
	int wb_count;
	int limit_cycles;
	int stall_cycles;

	core_top dut (
		.clk       (clk),
		.rstn      (rstn),
		.o_i_addr  (imem_addr),
		.i_i_rdata (imem_rdata),
		.o_wb      (wb)
	);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	task automatic halt_with_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic match_wb(input wb_t got, input wb_t exp);
		if (got.valid !== exp.valid)
			halt_with_error($sformatf("mismatch o_wb.valid got %h exp %h", got.valid, exp.valid));
		if (exp.valid && got.dd !== exp.dd)
			halt_with_error($sformatf("mismatch o_wb.dd got %h exp %h", got.dd, exp.dd));
		if (exp.valid && got.data !== exp.data)
			halt_with_error($sformatf("mismatch o_wb.data got %h exp %h", got.data, exp.data));
	endtask

	task automatic verify_count(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
		if (got !== exp)
			halt_with_error($sformatf("mismatch writeback count got %h exp %h", got, exp));
	endtask

	task automatic expect_addr(input logic [pc_w-1:0] got, input logic [pc_w-1:0] exp);
		if (got !== exp)
			halt_with_error($sformatf("mismatch o_i_addr got %h exp %h", got, exp));
	endtask

	function automatic logic [instr_w-1:0] word_at(input int idx);
		return (idx < prog.size()) ? prog[idx] : '0;
	endfunction

	task automatic put_instr(input opcode_t op, input int dd, input int ds, input int dt,
			input int imm);
		logic [instr_w-1:0] w;
		if (op == nop)
			w = '0;
		else if (op == addi || op == shli)
			w = {op, reg_idx_t'(dd), reg_idx_t'(ds), imm_t'(imm)};
		else
			w = {op, reg_idx_t'(dd), reg_idx_t'(ds), reg_idx_t'(dt), 11'h000};
		prog.push_back(w);
	endtask

	// in-order result of one instruction from its operand values
	function automatic logic [xlen-1:0] expected_result(input logic [instr_w-1:0] w,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [15:0] imm;
		logic [xlen-1:0] res;
		imm = w[15:0];
		case (w[31:26])
			add:     res = a + b;
			sub:     res = a - b;
			and_op:  res = a & b;
			or_op:   res = a | b;
			xor_op:  res = a ^ b;
			addi:    res = a + {{16{imm[15]}}, imm};
			shli:    res = a << imm[4:0];
			mul:     res = a * b;
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic build_expectations();
		logic [xlen-1:0] model [nreg];
		logic [instr_w-1:0] w;
		reg_idx_t dd;
		reg_idx_t ds;
		reg_idx_t dt;
		logic [xlen-1:0] res;
		wb_t entry;
		for (int r = 0; r < nreg; r++)
			model[r] = '0;
		exp_total = 0;
		for (int n = 0; n < prog.size(); n++) begin
			w = prog[n];
			dd = w[25:21];
			ds = w[20:16];
			dt = w[15:11];
			res = expected_result(w, model[ds], model[dt]);
			// nothing lands in r0
			if (w[31:26] != nop && dd != '0) begin
				model[dd] = res;
				entry.valid = 1'b1;
				entry.dd = dd;
				entry.data = res;
				exp_q[dd].push_back(entry);
				exp_total++;
			end
		end
	endtask

	task automatic add_directed_block();
		// independent alu and immediate ops
		put_instr(add, 10, 1, 2, 0);
		put_instr(sub, 11, 3, 4, 0);
		put_instr(and_op, 12, 5, 6, 0);
		put_instr(or_op, 13, 7, 8, 0);
		put_instr(xor_op, 14, 9, 15, 0);
		put_instr(addi, 16, 17, 0, -5);
		put_instr(shli, 18, 19, 0, 4);
		// raw chain, then war, then waw behind a mul
		put_instr(addi, 1, 1, 0, 1);
		put_instr(add, 2, 1, 1, 0);
		put_instr(sub, 3, 2, 1, 0);
		put_instr(xor_op, 4, 3, 2, 0);
		put_instr(add, 5, 6, 7, 0);
		put_instr(addi, 6, 8, 0, 100);
		put_instr(mul, 9, 10, 11, 0);
		put_instr(addi, 9, 12, 0, 3);
		put_instr(add, 20, 9, 9, 0);
		// muls mixed with younger alu ops
		put_instr(mul, 21, 1, 2, 0);
		put_instr(add, 22, 3, 4, 0);
		put_instr(mul, 23, 21, 5, 0);
		put_instr(or_op, 24, 6, 7, 0);
		put_instr(mul, 25, 8, 9, 0);
		put_instr(mul, 26, 10, 11, 0);
		put_instr(mul, 27, 12, 13, 0);
		put_instr(xor_op, 28, 14, 15, 0);
		// r0 as source and as destination
		put_instr(add, 29, 0, 3, 0);
		put_instr(addi, 0, 5, 0, 77);
		put_instr(add, 30, 0, 0, 0);
		put_instr(nop, 0, 0, 0, 0);
		put_instr(nop, 0, 0, 0, 0);
		put_instr(mul, 0, 1, 2, 0);
		put_instr(or_op, 31, 0, 4, 0);
	endtask

	task automatic add_random_block(input int count);
		opcode_t ops [9];
		ops = '{nop, add, sub, and_op, or_op, xor_op, addi, shli, mul};
		// few registers, so dependencies are dense
		for (int n = 0; n < count; n++)
			put_instr(ops[$urandom % 9], $urandom % 8, $urandom % 8, $urandom % 8,
				$urandom % 65536);
	endtask

	// synchronous instruction memory, one pair per address
	initial begin
		logic [pc_w-1:0] addr_q;
		addr_q = '0;
		imem_rdata = '0;
		forever begin
			@(negedge clk);
			imem_rdata = {word_at(2*int'(addr_q)), word_at(2*int'(addr_q) + 1)};
			addr_q = imem_addr;
		end
	end

	initial begin
		wb_t exp_wb;
		forever begin
			@(negedge clk);
			if (wb.valid === 1'b1) begin
				if (exp_q[wb.dd].size() == 0)
					halt_with_error($sformatf("writeback to r%0d that no instruction expects",
						wb.dd));
				exp_wb = exp_q[wb.dd].pop_front();
				match_wb(wb, exp_wb);
				wb_count++;
			end
		end
	end

	initial begin
		stall_cycles = 0;
		forever begin
			@(negedge clk);
			if (dut.stall === 1'b1)
				stall_cycles++;
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout after %0d cycles, %0d of %0d writebacks missing", limit_cycles,
			exp_total - wb_count, exp_total);
		for (int r = 0; r < nreg; r++)
			if (exp_q[r].size() > 0)
				$display("r%0d still waits for %0d writebacks", r, exp_q[r].size());
		halt_with_error("the core stopped producing writebacks before the program ended");
	end

	initial begin
		logic [pc_w-1:0] start_addr [4];
		wb_t idle_wb;
		int last_pair;
		rstn = 1'b0;
		wb_count = 0;
		limit_cycles = 0;
		void'($urandom(seed));
		// give every register a known value first
		for (int r = 1; r < nreg; r++)
			put_instr(addi, r, 0, 0, r*97 + 3);
		add_directed_block();
		add_random_block(random_count);
		build_expectations();
		limit_cycles = 20*prog.size() + 300;
		last_pair = (prog.size() + 1) / 2 - 1;
		start_addr = '{0, 0, 1, 2};
		idle_wb = '0;
		repeat (reset_cycles) @(negedge clk);
		rstn = 1'b1;
		// begin cycle, then the counter steps
		for (int k = 0; k < 4; k++) begin
			expect_addr(imem_addr, start_addr[k]);
			match_wb(wb, idle_wb);
			@(negedge clk);
		end
		// whole program requested once fetch moves past its last pair
		wait (int'(imem_addr) > last_pair);
		repeat (drain_cycles) @(negedge clk);
		verify_count(xlen'(wb_count), xlen'(exp_total));
		if (stall_cycles == 0)
			halt_with_error("the window never stalled fetch during the run");
		else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: build.f
hdl/core_pkg.sv
hdl/isa_pkg.sv
hdl/fetch_control.sv
hdl/issue_window.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/core_top.sv
bench/core_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := core_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
